//--- Bender.yml
package:
  name: status_subsys

export_include_dirs:
  - include

sources:
  # rtl in compile order
  - include_dirs:
      - include
    files:
      - source/status_pkg.sv
      - source/status_dispatch.sv
      - source/status_port.sv
      - source/status_arbiter.sv
      - source/status_subsys.sv

  # testbench and bound assertions
  - target: test
    include_dirs:
      - include
    files:
      - dv/status_sva.sv
      - dv/status_tb.sv

//--- dv/status_sva.sv
/*
  status network assertions
  grant, valid and packet framing checks bound into the subsystem
*/
`timescale 1ns/100ps
`include "status_consts.svh"

module status_sva (
  input logic                         clk,
  input logic                         rst_n,
  input logic [`STATUS_NUM_PORTS-1:0] net_req_i,
  input logic [`STATUS_NUM_PORTS-1:0] net_ack_i,
  input logic [`STATUS_NUM_PORTS-1:0] net_valid_i,
  input logic                         out_valid_i
);

  // ------------------------------
  // grant rules
  // ------------------------------
  // one grant at a time
  a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(net_ack_i))
    else $error("more than one net_ack high");

  // grant released the cycle after its request falls
  a_ack_release: assert property (@(posedge clk) disable iff (!rst_n)
    |(net_ack_i & ~net_req_i) |=> (net_ack_i == '0))
    else $error("net_ack held after its request fell");

  // ports drive words only under their own grant
  a_valid_granted: assert property (@(posedge clk) disable iff (!rst_n)
    (net_valid_i & ~net_ack_i) == '0)
    else $error("port word without grant");

  // ------------------------------
  // output framing
  // ------------------------------
  // three words, then a gap
  a_three_words: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(out_valid_i) |-> out_valid_i [*`STATUS_PKT_WORDS] ##1 !out_valid_i)
    else $error("output packet not three words long");

endmodule

bind status_subsys status_sva sva_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .net_req_i   (net_req),
  .net_ack_i   (net_ack),
  .net_valid_i (net_valid),
  .out_valid_i (net_valid_o)
);

//--- dv/status_tb.sv
/*
  status subsystem testbench
  lfsr driven events, output packets checked against a per-port model
*/
`timescale 1ns/100ps
`include "status_consts.svh"

module status_tb;
  import status_pkg::*;

  localparam int EVENTS     = 200;
  localparam int MAX_CYCLES = EVENTS * 40;

  logic                          clk;
  logic                          rst_n;
  logic                          evt_req;
  logic                          evt_ack;
  logic [`STATUS_PORT_W-1:0]     evt_port;
  status_kind_e                  evt_kind;
  logic [`STATUS_VR_ID_W-1:0]    evt_vr_id;
  logic [`STATUS_VR_FR_W-1:0]    evt_vr_fr;
  logic [`STATUS_CHAN_W-1:0]     evt_chan;
  logic [`STATUS_POS1_W-1:0]     evt_pos1;
  logic [`STATUS_POS2_W-1:0]     evt_pos2;
  logic [`STATUS_SRC_W-1:0]      evt_src;
  logic                          net_valid;
  logic [`STATUS_WORD_W-1:0]     net_data;
  logic [`STATUS_NUM_PORTS-1:0]  idle;

  // expected words and kinds per port
  logic [`STATUS_WORD_W-1:0] exp_words [`STATUS_NUM_PORTS][$];
  status_kind_e              exp_kinds [`STATUS_NUM_PORTS][$];
  logic [`STATUS_WORD_W-1:0] cur_words [`STATUS_PKT_WORDS];
  int                        word_pos;
  int                        pkt_done;
  int                        stall_cnt;
  int                        cycle_cnt;
  logic [15:0]               lfsr_state;

  status_subsys dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .evt_req_i   (evt_req),
    .evt_ack_o   (evt_ack),
    .evt_port_i  (evt_port),
    .evt_kind_i  (evt_kind),
    .evt_vr_id_i (evt_vr_id),
    .evt_vr_fr_i (evt_vr_fr),
    .evt_chan_i  (evt_chan),
    .evt_pos1_i  (evt_pos1),
    .evt_pos2_i  (evt_pos2),
    .evt_src_i   (evt_src),
    .net_valid_o (net_valid),
    .net_data_o  (net_data),
    .idle_o      (idle)
  );

  always #4 clk = ~clk;

  // ------------------------------
  // random source
  // ------------------------------
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    // taps 16 14 13 11
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // ------------------------------
  // failure and compare
  // ------------------------------
  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input logic [`STATUS_WORD_W-1:0] got,
                            input logic [`STATUS_WORD_W-1:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("error %0t: %s got %08h expected %08h", $time, what, got, exp));
    end
  endtask

  task automatic check_kind(input status_kind_e got, input status_kind_e exp,
                            input string what);
    if (got !== exp) begin
      abort_run($sformatf("error %0t: %s got %s expected %s", $time, what,
                          got.name(), exp.name()));
    end
  endtask

  task automatic check_idle(input logic [`STATUS_NUM_PORTS-1:0] got,
                            input logic [`STATUS_NUM_PORTS-1:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("error %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("error %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  // ------------------------------
  // packet model
  // ------------------------------
  // word 0 from the fields on the event bus
  function automatic logic [`STATUS_WORD_W-1:0] expect_word0();
    logic [`STATUS_WORD_W-1:0] w;
    w = '0;
    if (evt_kind == KIND_RELEASE) begin
      w[31]    = 1'b1;
      w[18:17] = evt_port;
      w[16:8]  = evt_vr_id;
      w[7:5]   = evt_vr_fr;
      w[4:0]   = evt_chan;
    end else begin
      w[21:20] = evt_src;
      w[18:16] = evt_pos2;
      w[9:8]   = evt_port;
      w[7:0]   = evt_pos1;
    end
    return w;
  endfunction

  function automatic int pending_packets();
    int n;
    n = 0;
    for (int k = 0; k < `STATUS_NUM_PORTS; k++) begin
      n += exp_kinds[k].size();
    end
    return n;
  endfunction

  // steer each output word by the port index in word 0
  task automatic take_word(input logic [`STATUS_WORD_W-1:0] data);
    status_kind_e              kind;
    logic [`STATUS_PORT_W-1:0] port;
    kind = status_kind_e'(data[31]);
    port = (kind == KIND_RELEASE) ? data[18:17] : data[9:8];
    if (word_pos == 0 && exp_kinds[port].size() == 0) begin
      abort_run($sformatf("error %0t: packet from port %0d with no pending event",
                          $time, port));
    end else begin
      if (word_pos == 0) begin
        check_kind(kind, exp_kinds[port].pop_front(), "packet kind");
        for (int i = 0; i < `STATUS_PKT_WORDS; i++) begin
          cur_words[i] = exp_words[port].pop_front();
        end
      end
      check_word(data, cur_words[word_pos], $sformatf("word %0d", word_pos));
      if (word_pos == `STATUS_PKT_WORDS - 1) begin
        word_pos = 0;
        pkt_done++;
      end else begin
        word_pos++;
      end
    end
  endtask

  always @(negedge clk) begin
    if (rst_n && net_valid) begin
      take_word(net_data);
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  task automatic send_event(input logic [`STATUS_PORT_W-1:0] port);
    logic was_idle;
    int   wait_cyc;
    evt_port  = port;
    evt_kind  = status_kind_e'(rand_bits(1));
    evt_vr_id = `STATUS_VR_ID_W'(rand_bits(`STATUS_VR_ID_W));
    evt_vr_fr = `STATUS_VR_FR_W'(rand_bits(`STATUS_VR_FR_W));
    evt_chan  = `STATUS_CHAN_W'(rand_bits(`STATUS_CHAN_W));
    evt_pos1  = `STATUS_POS1_W'(rand_bits(`STATUS_POS1_W));
    evt_pos2  = `STATUS_POS2_W'(rand_bits(`STATUS_POS2_W));
    evt_src   = `STATUS_SRC_W'(rand_bits(`STATUS_SRC_W));
    exp_kinds[port].push_back(evt_kind);
    exp_words[port].push_back(expect_word0());
    // word 1 is the pos_1st nibble only for a write ack
    exp_words[port].push_back((evt_kind == KIND_RELEASE) ? '0 : `STATUS_WORD_W'(evt_pos1[3:0]));
    exp_words[port].push_back(`STATUS_WORD_W'(1));
    was_idle = idle[port];
    evt_req  = 1'b1;
    wait_cyc = 0;
    do begin
      @(negedge clk);
      wait_cyc++;
    end while (!evt_ack);
    // idle target acks after two cycles
    if (was_idle && wait_cyc != 2) begin
      abort_run($sformatf("error %0t: ack after %0d cycles to idle port %0d",
                          $time, wait_cyc, port));
    end
    if (wait_cyc > 2) begin
      stall_cnt++;
    end
    evt_req = 1'b0;
    do begin
      @(negedge clk);
    end while (evt_ack);
  endtask

  // run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      abort_run($sformatf("timeout after %0d cycles with %0d of %0d packets received",
                          cycle_cnt, pkt_done, EVENTS));
    end
  end

  initial begin
    logic [`STATUS_PORT_W-1:0] burst_port;
    logic [`STATUS_PORT_W-1:0] port;
    int                        gap;
    clk = 1'b0;
    rst_n = 1'b0;
    evt_req = 1'b0;
    evt_port = '0;
    evt_kind = KIND_WRITE_ACK;
    evt_vr_id = '0;
    evt_vr_fr = '0;
    evt_chan = '0;
    evt_pos1 = '0;
    evt_pos2 = '0;
    evt_src = '0;
    lfsr_state = 16'd76;
    word_pos = 0;
    pkt_done = 0;
    stall_cnt = 0;
    cycle_cnt = 0;
    burst_port = '0;
    repeat (16) @(negedge clk);
    check_bit(evt_ack, 1'b0, "evt_ack_o in reset");
    check_bit(net_valid, 1'b0, "net_valid_o in reset");
    check_idle(idle, '1, "idle_o in reset");
    rst_n = 1'b1;
    for (int n = 0; n < EVENTS; n++) begin
      // every third group of eight hits one port
      if (n % 8 == 0) begin
        burst_port = `STATUS_PORT_W'(rand_bits(`STATUS_PORT_W));
      end
      port = ((n / 8) % 3 == 0) ? burst_port : `STATUS_PORT_W'(rand_bits(`STATUS_PORT_W));
      gap  = int'(rand_bits(2));
      repeat (gap) @(negedge clk);
      send_event(port);
    end
    // wait for every port to finish its last packet
    while (idle !== '1) @(negedge clk);
    repeat (3) @(negedge clk);
    check_idle(idle, '1, "idle_o after last packet");
    repeat (10) @(negedge clk);
    if (pending_packets() == 0 && word_pos == 0 && stall_cnt > 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      abort_run($sformatf("run ended with %0d packets pending and %0d stalled events",
                          pending_packets(), stall_cnt));
    end
  end

endmodule

//--- include/status_consts.svh
/*
  status network constants
  port count, network word size and event field widths
*/
`ifndef STATUS_CONSTS_SVH
`define STATUS_CONSTS_SVH

// ------------------------------
// network shape
// ------------------------------
`define STATUS_NUM_PORTS 4
`define STATUS_PORT_W    2
`define STATUS_WORD_W    32
// words per packet, last one is the end marker
`define STATUS_PKT_WORDS 3

// ------------------------------
// event field widths
// ------------------------------
// release fields
`define STATUS_VR_ID_W   9
`define STATUS_VR_FR_W   3
`define STATUS_CHAN_W    5
// write ack fields
`define STATUS_POS1_W    8
`define STATUS_POS2_W    3
`define STATUS_SRC_W     2

`endif

//--- list.f
+incdir+include
source/status_pkg.sv
source/status_dispatch.sv
source/status_port.sv
source/status_arbiter.sv
source/status_subsys.sv
dv/status_sva.sv
dv/status_tb.sv

//--- source/status_arbiter.sv
/*
  status network arbiter
  round-robin grant among ports, granted words registered onto the output
*/
`timescale 1ns/100ps
`include "status_consts.svh"

module status_arbiter (
  input  logic                                            clk,
  input  logic                                            rst_n,
  // per-port request and grant
  input  logic [`STATUS_NUM_PORTS-1:0]                    net_req_i,
  output logic [`STATUS_NUM_PORTS-1:0]                    net_ack_o,
  // per-port words
  input  logic [`STATUS_NUM_PORTS-1:0]                    net_valid_i,
  input  logic [`STATUS_NUM_PORTS-1:0][`STATUS_WORD_W-1:0] net_data_i,
  // shared output stream
  output logic                                            net_valid_o,
  output logic [`STATUS_WORD_W-1:0]                       net_data_o
);

  // ------------------------------
  // grant state
  // ------------------------------
  logic [`STATUS_NUM_PORTS-1:0] gnt_q;
  // last winner, also the current grantee while busy
  logic [`STATUS_PORT_W-1:0]    last_q;
  logic                         busy;

  // next-winner search
  logic                         pick_found;
  logic [`STATUS_PORT_W-1:0]    pick_idx;
  logic [`STATUS_PORT_W-1:0]    cand;

  // output registers
  logic                         net_valid_q;
  logic [`STATUS_WORD_W-1:0]    net_data_q;

  assign busy = |gnt_q;

  // start after last winner, wrap around, last winner last
  always_comb begin
    pick_found = 1'b0;
    pick_idx   = last_q;
    cand       = last_q;
    for (int i = 1; i <= `STATUS_NUM_PORTS; i++) begin
      cand = last_q + `STATUS_PORT_W'(i);
      if (!pick_found && net_req_i[cand]) begin
        pick_found = 1'b1;
        pick_idx   = cand;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gnt_q  <= '0;
      // port 0 gets first turn
      last_q <= '1;
    end else if (!busy) begin
      if (pick_found) begin
        gnt_q  <= `STATUS_NUM_PORTS'(1) << pick_idx;
        last_q <= pick_idx;
      end
    end else if (!net_req_i[last_q]) begin
      // request fell, release grant for one cycle
      gnt_q <= '0;
    end
  end

  // ------------------------------
  // output stream
  // ------------------------------
  // only the granted port's words pass
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      net_valid_q <= 1'b0;
    end else begin
      net_valid_q <= busy & net_valid_i[last_q];
    end
  end

  always_ff @(posedge clk) begin
    net_data_q <= net_data_i[last_q];
  end

  assign net_ack_o   = gnt_q;
  assign net_valid_o = net_valid_q;
  assign net_data_o  = net_data_q;

endmodule

//--- source/status_dispatch.sv
/*
  status event dispatcher
  holds one incoming event and hands it to its target status port
*/
`timescale 1ns/100ps
`include "status_consts.svh"

module status_dispatch (
  input  logic                          clk,
  input  logic                          rst_n,
  // event source, four-phase
  input  logic                          evt_req_i,
  output logic                          evt_ack_o,
  input  logic [`STATUS_PORT_W-1:0]     evt_port_i,
  input  status_pkg::status_kind_e      evt_kind_i,
  input  logic [`STATUS_VR_ID_W-1:0]    evt_vr_id_i,
  input  logic [`STATUS_VR_FR_W-1:0]    evt_vr_fr_i,
  input  logic [`STATUS_CHAN_W-1:0]     evt_chan_i,
  input  logic [`STATUS_POS1_W-1:0]     evt_pos1_i,
  input  logic [`STATUS_POS2_W-1:0]     evt_pos2_i,
  input  logic [`STATUS_SRC_W-1:0]      evt_src_i,
  // load handshake, one pair per port
  output logic [`STATUS_NUM_PORTS-1:0]  load_req_o,
  input  logic [`STATUS_NUM_PORTS-1:0]  load_ack_i,
  // shared field buses
  output status_pkg::status_kind_e      ld_kind_o,
  output logic [`STATUS_VR_ID_W-1:0]    ld_vr_id_o,
  output logic [`STATUS_VR_FR_W-1:0]    ld_vr_fr_o,
  output logic [`STATUS_CHAN_W-1:0]     ld_chan_o,
  output logic [`STATUS_POS1_W-1:0]     ld_pos1_o,
  output logic [`STATUS_POS2_W-1:0]     ld_pos2_o,
  output logic [`STATUS_SRC_W-1:0]      ld_src_o
);
  import status_pkg::*;

  // ------------------------------
  // handshake control
  // ------------------------------
  logic [`STATUS_NUM_PORTS-1:0] load_req_q;
  logic                         evt_ack_q;
  logic                         accept;
  logic                         tgt_ack;

  // holding register
  logic [`STATUS_PORT_W-1:0]  port_q;
  status_kind_e               kind_q;
  logic [`STATUS_VR_ID_W-1:0] vr_id_q;
  logic [`STATUS_VR_FR_W-1:0] vr_fr_q;
  logic [`STATUS_CHAN_W-1:0]  chan_q;
  logic [`STATUS_POS1_W-1:0]  pos1_q;
  logic [`STATUS_POS2_W-1:0]  pos2_q;
  logic [`STATUS_SRC_W-1:0]   src_q;

  // free only when both handshakes are closed
  assign accept  = evt_req_i & ~evt_ack_q & ~(|load_req_q);
  // ack from the port we are loading
  assign tgt_ack = load_ack_i[port_q];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      load_req_q <= '0;
      evt_ack_q  <= 1'b0;
    end else if (accept) begin
      // one-hot request to target port
      load_req_q <= `STATUS_NUM_PORTS'(1) << evt_port_i;
    end else if (|load_req_q) begin
      // stalls here while the port is busy
      if (tgt_ack) begin
        load_req_q <= '0;
        evt_ack_q  <= 1'b1;
      end
    end else if (evt_ack_q && !evt_req_i && !tgt_ack) begin
      // source released and port ack gone
      evt_ack_q <= 1'b0;
    end
  end

  // capture event fields
  always_ff @(posedge clk) begin
    if (accept) begin
      port_q  <= evt_port_i;
      kind_q  <= evt_kind_i;
      vr_id_q <= evt_vr_id_i;
      vr_fr_q <= evt_vr_fr_i;
      chan_q  <= evt_chan_i;
      pos1_q  <= evt_pos1_i;
      pos2_q  <= evt_pos2_i;
      src_q   <= evt_src_i;
    end
  end

  // ------------------------------
  // outputs
  // ------------------------------
  assign evt_ack_o  = evt_ack_q;
  assign load_req_o = load_req_q;
  assign ld_kind_o  = kind_q;
  assign ld_vr_id_o = vr_id_q;
  assign ld_vr_fr_o = vr_fr_q;
  assign ld_chan_o  = chan_q;
  assign ld_pos1_o  = pos1_q;
  assign ld_pos2_o  = pos2_q;
  assign ld_src_o   = src_q;

endmodule

//--- source/status_pkg.sv
/*
  status network types
  event kind and status port state encodings
*/
package status_pkg;

  // ------------------------------
  // event kind
  // ------------------------------
  // one bit, high means release request
  typedef enum logic {
    KIND_WRITE_ACK = 1'b0,
    KIND_RELEASE   = 1'b1
  } status_kind_e;

  // ------------------------------
  // status port fsm
  // ------------------------------
  // one-hot encoding
  typedef enum logic [3:0] {
    PORT_IDLE = 4'b0001,
    PORT_REQ  = 4'b0010,
    PORT_SEND = 4'b0100,
    // waiting for net_ack to fall
    PORT_DONE = 4'b1000
  } port_state_e;

endpackage

//--- source/status_port.sv
/*
  status port
  captures one event, builds its three-word packet and sends it on grant
*/
`timescale 1ns/100ps
`include "status_consts.svh"

module status_port #(
  parameter int PORT_ID = 0
) (
  input  logic                        clk,
  input  logic                        rst_n,
  // load handshake from dispatcher
  input  logic                        load_req_i,
  output logic                        load_ack_o,
  input  status_pkg::status_kind_e    ld_kind_i,
  input  logic [`STATUS_VR_ID_W-1:0]  ld_vr_id_i,
  input  logic [`STATUS_VR_FR_W-1:0]  ld_vr_fr_i,
  input  logic [`STATUS_CHAN_W-1:0]   ld_chan_i,
  input  logic [`STATUS_POS1_W-1:0]   ld_pos1_i,
  input  logic [`STATUS_POS2_W-1:0]   ld_pos2_i,
  input  logic [`STATUS_SRC_W-1:0]    ld_src_i,
  // status network side
  output logic                        net_req_o,
  input  logic                        net_ack_i,
  output logic                        net_valid_o,
  output logic [`STATUS_WORD_W-1:0]   net_data_o,
  output logic                        idle_o
);
  import status_pkg::*;

  // port index doubles as node id
  localparam logic [`STATUS_PORT_W-1:0] NODE_ID = `STATUS_PORT_W'(PORT_ID);
  localparam logic [1:0] LAST_WORD = 2'(`STATUS_PKT_WORDS - 1);

  port_state_e state_q;
  port_state_e state_d;
  logic [1:0]  cnt_q;
  logic        ack_hold_q;
  logic        capture;

  // event kind and release fields
  status_kind_e               kind_q;
  logic [`STATUS_VR_ID_W-1:0] vr_id_q;
  logic [`STATUS_VR_FR_W-1:0] vr_fr_q;
  logic [`STATUS_CHAN_W-1:0]  chan_q;
  // write ack fields
  logic [`STATUS_POS1_W-1:0]  pos1_q;
  logic [`STATUS_POS2_W-1:0]  pos2_q;
  logic [`STATUS_SRC_W-1:0]   src_q;

  logic [`STATUS_WORD_W-1:0]  rel_word0;
  logic [`STATUS_WORD_W-1:0]  ack_word0;
  logic [`STATUS_WORD_W-1:0]  ack_word1;
  logic [`STATUS_WORD_W-1:0]  word;

  // ------------------------------
  // load capture
  // ------------------------------
  // only an idle port takes a new event
  assign capture    = load_req_i & (state_q == PORT_IDLE);
  // ack stays up until dispatcher drops its request
  assign load_ack_o = load_req_i & ((state_q == PORT_IDLE) | ack_hold_q);

  always_ff @(posedge clk) begin
    if (capture) begin
      kind_q <= ld_kind_i;
    end
    if (capture && ld_kind_i == KIND_RELEASE) begin
      vr_id_q <= ld_vr_id_i;
      vr_fr_q <= ld_vr_fr_i;
      chan_q  <= ld_chan_i;
    end
    if (capture && ld_kind_i == KIND_WRITE_ACK) begin
      pos1_q <= ld_pos1_i;
      pos2_q <= ld_pos2_i;
      src_q  <= ld_src_i;
    end
  end

  // ------------------------------
  // state machine
  // ------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      PORT_IDLE: if (load_req_i) state_d = PORT_REQ;
      PORT_REQ:  if (net_ack_i) state_d = PORT_SEND;
      PORT_SEND: if (cnt_q == LAST_WORD) state_d = PORT_DONE;
      // close the network four-phase cycle
      PORT_DONE: if (!net_ack_i) state_d = PORT_IDLE;
      default:   state_d = PORT_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q    <= PORT_IDLE;
      cnt_q      <= '0;
      ack_hold_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // word counter runs only while sending
      if (state_q == PORT_SEND) begin
        cnt_q <= cnt_q + 2'd1;
      end else begin
        cnt_q <= '0;
      end
      if (capture) begin
        ack_hold_q <= 1'b1;
      end else if (!load_req_i) begin
        ack_hold_q <= 1'b0;
      end
    end
  end

  // ------------------------------
  // packet words
  // ------------------------------
  // release: flag, node id, vr id, vr fr, channel
  assign rel_word0 = {1'b1, 12'b0, NODE_ID, vr_id_q, vr_fr_q, chan_q};
  // write ack: src type, pos 2nd, node id, pos 1st
  assign ack_word0 = {10'b0, src_q, 1'b0, pos2_q, 6'b0, NODE_ID, pos1_q};
  // low nibble of pos 1st
  assign ack_word1 = {28'b0, pos1_q[3:0]};

  always_comb begin
    case (cnt_q)
      2'd0:    word = (kind_q == KIND_RELEASE) ? rel_word0 : ack_word0;
      2'd1:    word = (kind_q == KIND_RELEASE) ? '0 : ack_word1;
      // end of packet marker
      default: word = `STATUS_WORD_W'(1);
    endcase
  end

  // ------------------------------
  // outputs
  // ------------------------------
  assign net_req_o   = (state_q == PORT_REQ) | (state_q == PORT_SEND);
  assign net_valid_o = (state_q == PORT_SEND);
  // bus quiet outside a packet
  assign net_data_o  = net_valid_o ? word : '0;
  assign idle_o      = (state_q == PORT_IDLE);

endmodule

//--- source/status_subsys.sv
/*
  status reporting subsystem
  dispatcher, four status ports and the network arbiter
*/
`timescale 1ns/100ps
`include "status_consts.svh"

module status_subsys (
  input  logic                          clk,
  input  logic                          rst_n,
  // event source
  input  logic                          evt_req_i,
  output logic                          evt_ack_o,
  input  logic [`STATUS_PORT_W-1:0]     evt_port_i,
  input  status_pkg::status_kind_e      evt_kind_i,
  input  logic [`STATUS_VR_ID_W-1:0]    evt_vr_id_i,
  input  logic [`STATUS_VR_FR_W-1:0]    evt_vr_fr_i,
  input  logic [`STATUS_CHAN_W-1:0]     evt_chan_i,
  input  logic [`STATUS_POS1_W-1:0]     evt_pos1_i,
  input  logic [`STATUS_POS2_W-1:0]     evt_pos2_i,
  input  logic [`STATUS_SRC_W-1:0]      evt_src_i,
  // status network output
  output logic                          net_valid_o,
  output logic [`STATUS_WORD_W-1:0]     net_data_o,
  output logic [`STATUS_NUM_PORTS-1:0]  idle_o
);
  import status_pkg::*;

  // ------------------------------
  // dispatcher to ports
  // ------------------------------
  logic [`STATUS_NUM_PORTS-1:0] load_req;
  logic [`STATUS_NUM_PORTS-1:0] load_ack;
  status_kind_e                 ld_kind;
  logic [`STATUS_VR_ID_W-1:0]   ld_vr_id;
  logic [`STATUS_VR_FR_W-1:0]   ld_vr_fr;
  logic [`STATUS_CHAN_W-1:0]    ld_chan;
  logic [`STATUS_POS1_W-1:0]    ld_pos1;
  logic [`STATUS_POS2_W-1:0]    ld_pos2;
  logic [`STATUS_SRC_W-1:0]     ld_src;

  // ports to arbiter
  logic [`STATUS_NUM_PORTS-1:0]                     net_req;
  logic [`STATUS_NUM_PORTS-1:0]                     net_ack;
  logic [`STATUS_NUM_PORTS-1:0]                     net_valid;
  logic [`STATUS_NUM_PORTS-1:0][`STATUS_WORD_W-1:0] net_data;

  status_dispatch dispatch_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .evt_req_i   (evt_req_i),
    .evt_ack_o   (evt_ack_o),
    .evt_port_i  (evt_port_i),
    .evt_kind_i  (evt_kind_i),
    .evt_vr_id_i (evt_vr_id_i),
    .evt_vr_fr_i (evt_vr_fr_i),
    .evt_chan_i  (evt_chan_i),
    .evt_pos1_i  (evt_pos1_i),
    .evt_pos2_i  (evt_pos2_i),
    .evt_src_i   (evt_src_i),
    .load_req_o  (load_req),
    .load_ack_i  (load_ack),
    .ld_kind_o   (ld_kind),
    .ld_vr_id_o  (ld_vr_id),
    .ld_vr_fr_o  (ld_vr_fr),
    .ld_chan_o   (ld_chan),
    .ld_pos1_o   (ld_pos1),
    .ld_pos2_o   (ld_pos2),
    .ld_src_o    (ld_src)
  );

  // ------------------------------
  // status ports
  // ------------------------------
  // loop index is the node id
  for (genvar k = 0; k < `STATUS_NUM_PORTS; k++) begin : g_port
    status_port #(
      .PORT_ID (k)
    ) port_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .load_req_i  (load_req[k]),
      .load_ack_o  (load_ack[k]),
      .ld_kind_i   (ld_kind),
      .ld_vr_id_i  (ld_vr_id),
      .ld_vr_fr_i  (ld_vr_fr),
      .ld_chan_i   (ld_chan),
      .ld_pos1_i   (ld_pos1),
      .ld_pos2_i   (ld_pos2),
      .ld_src_i    (ld_src),
      .net_req_o   (net_req[k]),
      .net_ack_i   (net_ack[k]),
      .net_valid_o (net_valid[k]),
      .net_data_o  (net_data[k]),
      .idle_o      (idle_o[k])
    );
  end

  status_arbiter arbiter_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .net_req_i   (net_req),
    .net_ack_o   (net_ack),
    .net_valid_i (net_valid),
    .net_data_i  (net_data),
    .net_valid_o (net_valid_o),
    .net_data_o  (net_data_o)
  );

endmodule
